/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_arrays.sv
      - rtl/plru_tree.sv
      - rtl/dcache_lookup.sv
      - rtl/miss_ctrl.sv
      - rtl/dcache_top.sv
  - target: test
    files:
      - verification/mem_model.sv
      - verification/tb_dcache.sv

/* dcache.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_arrays.sv
rtl/plru_tree.sv
rtl/dcache_lookup.sv
rtl/miss_ctrl.sv
rtl/dcache_top.sv
verification/mem_model.sv
verification/tb_dcache.sv

/* rtl/dcache_arrays.sv */
/*
 * cache storage, one bank per way
 * valid, dirty, tag and line arrays with a registered read port
 * and a write port where a same-index write is bypassed to the read
 */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_arrays (
    input  logic                             clk,
    input  logic                             rst_n,
    input  dcache_pkg::index_t               rd_index,
    output dcache_pkg::tagv_t [`DC_WAYS-1:0] tagv_rdata,
    output dcache_pkg::way_vec_t             dirty_rdata,
    output dcache_pkg::line_t [`DC_WAYS-1:0] line_rdata,
    input  dcache_pkg::index_t               wr_index,
    input  dcache_pkg::way_vec_t             line_we,
    input  dcache_pkg::line_t                line_wdata,
    input  dcache_pkg::way_vec_t             tagv_we,
    input  dcache_pkg::tagv_t                tagv_wdata,
    input  dcache_pkg::way_vec_t             dirty_we,
    input  logic                             dirty_wdata
);
    import dcache_pkg::*;

    logic same_index;

    assign same_index = (wr_index == rd_index);

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        logic [`DC_SETS-1:0] valid_bits;
        logic [`DC_SETS-1:0] dirty_bits;
        tag_t                tag_mem  [`DC_SETS];
        line_t               line_mem [`DC_SETS];
        logic                valid_q;
        logic                dirty_q;
        tag_t                tag_q;
        line_t               line_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_bits <= '0;
                dirty_bits <= '0;
                valid_q    <= 1'b0;
                dirty_q    <= 1'b0;
            end else begin
                if (tagv_we[w])
                    valid_bits[wr_index] <= tagv_wdata.valid;
                if (dirty_we[w])
                    dirty_bits[wr_index] <= dirty_wdata;
                valid_q <= (tagv_we[w] && same_index) ? tagv_wdata.valid : valid_bits[rd_index];
                dirty_q <= (dirty_we[w] && same_index) ? dirty_wdata : dirty_bits[rd_index];
            end
        end

        always_ff @(posedge clk) begin
            if (tagv_we[w])
                tag_mem[wr_index] <= tagv_wdata.tag;
            if (line_we[w])
                line_mem[wr_index] <= line_wdata;
            tag_q  <= (tagv_we[w] && same_index) ? tagv_wdata.tag : tag_mem[rd_index];
            line_q <= (line_we[w] && same_index) ? line_wdata : line_mem[rd_index];
        end

        assign tagv_rdata[w]  = '{valid: valid_q, tag: tag_q};
        assign dirty_rdata[w] = dirty_q;
        assign line_rdata[w]  = line_q;
    end

    // no store write may land in a refill cycle
    a_refill_alone: assert property (@(posedge clk) disable iff (!rst_n)
        (|tagv_we) |-> (line_we == tagv_we))
        else $error("store write collides with refill");

endmodule

/* rtl/dcache_config.svh */
/*
 * data cache geometry
 * sizes of the address fields, words, ways and sets
 */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

`define DC_ADDR_W      32
`define DC_DATA_W      32
`define DC_LINE_WORDS  4
`define DC_WAYS        4
`define DC_SETS        16

// address split into tag | index | byte offset
`define DC_OFFSET_W    4
`define DC_INDEX_W     4
`define DC_TAG_W       24

`endif

/* rtl/dcache_lookup.sv */
/*
 * lookup stage
 * request register, 4-way tag compare, store merge with a one-entry
 * store buffer and forwarding, load word select and extension
 */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_lookup (
    input  logic                             clk,
    input  logic                             rst_n,
    input  dcache_pkg::cpu_req_t             req,
    output logic                             busy,
    output logic [`DC_DATA_W-1:0]            rdata,
    output dcache_pkg::index_t               rd_index,
    input  dcache_pkg::tagv_t [`DC_WAYS-1:0] tagv_rdata,
    input  dcache_pkg::way_vec_t             dirty_rdata,
    input  dcache_pkg::line_t [`DC_WAYS-1:0] line_rdata,
    input  dcache_pkg::way_id_t              victim,
    output dcache_pkg::way_vec_t             hit_vec,
    output logic                             plru_update,
    output logic                             miss,
    output dcache_pkg::tag_t                 miss_tag,
    output dcache_pkg::index_t               miss_index,
    output dcache_pkg::tagv_t                victim_tagv,
    output logic                             victim_dirty,
    output dcache_pkg::line_t                victim_line,
    input  logic                             refill_done,
    output dcache_pkg::way_vec_t             store_we,
    output dcache_pkg::index_t               store_index,
    output dcache_pkg::line_t                store_line,
    output dcache_pkg::way_vec_t             dirty_we
);
    import dcache_pkg::*;

    typedef struct packed {
        logic     clean;   // line was clean before this store
        way_vec_t way;
        index_t   index;
        line_t    line;
    } store_buf_t;

    cpu_req_t              req_q;
    store_buf_t            sb;
    logic                  sb_valid;
    tag_t                  req_tag;
    index_t                req_index;
    offset_t               req_offset;
    logic [1:0]            word_sel;
    way_vec_t              sb_match;
    way_vec_t              dirty_fwd;
    line_t [`DC_WAYS-1:0]  line_fwd;
    line_t                 hit_line;
    line_t                 merged_line;
    logic [`DC_DATA_W-1:0] hit_word;
    logic [`DC_DATA_W-1:0] merged_word;
    logic [7:0]            byte_sel;
    logic [15:0]           half_sel;
    logic                  accept;
    logic                  store_accept;

    assign req_tag    = addr_tag(req_q.addr);
    assign req_index  = addr_index(req_q.addr);
    assign req_offset = addr_offset(req_q.addr);
    assign word_sel   = req_offset[`DC_OFFSET_W-1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            req_q <= '0;
        else if (!busy)
            req_q <= req;
    end

    // keep reading the buffered set while the miss is serviced
    assign rd_index = busy ? req_index : addr_index(req.addr);

    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_cmp
        assign sb_match[w] = sb_valid && sb.way[w] && (sb.index == req_index);
        assign line_fwd[w] = sb_match[w] ? sb.line : line_rdata[w];
        assign hit_vec[w]  = tagv_rdata[w].valid && (tagv_rdata[w].tag == req_tag);
    end
    assign dirty_fwd = dirty_rdata | sb_match;

    assign busy         = req_q.valid && (!(|hit_vec) || refill_done);
    assign miss         = req_q.valid && !(|hit_vec);
    assign accept       = req_q.valid && (|hit_vec) && !refill_done;
    assign store_accept = accept && (req_q.op == OP_STORE);
    assign plru_update  = accept;

    assign miss_tag     = req_tag;
    assign miss_index   = req_index;
    assign victim_tagv  = tagv_rdata[victim];
    assign victim_dirty = dirty_fwd[victim];
    assign victim_line  = line_fwd[victim];

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit_vec[w])
                hit_line = hit_line | line_fwd[w];
        end
    end
    assign hit_word = hit_line[word_sel];

    always_comb begin
        merged_word = hit_word;
        for (int b = 0; b < 4; b++) begin
            if (req_q.wstrb[b])
                merged_word[8*b +: 8] = req_q.wdata[8*b +: 8];
        end
        merged_line           = hit_line;
        merged_line[word_sel] = merged_word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sb_valid <= 1'b0;
        else
            sb_valid <= store_accept;
    end

    always_ff @(posedge clk) begin
        if (store_accept) begin
            sb.clean <= !(|(dirty_fwd & hit_vec));
            sb.way   <= hit_vec;
            sb.index <= req_index;
            sb.line  <= merged_line;
        end
    end

    assign store_we    = sb_valid ? sb.way : '0;
    assign store_index = sb.index;
    assign store_line  = sb.line;
    assign dirty_we    = (sb_valid && sb.clean) ? sb.way : '0;

    assign byte_sel = hit_word[{req_offset[1:0], 3'b000} +: 8];
    assign half_sel = req_offset[1] ? hit_word[31:16] : hit_word[15:0];

    always_comb begin
        case (req_q.load_type)
            LD_B:    rdata = {{24{byte_sel[7]}}, byte_sel};
            LD_BU:   rdata = {24'b0, byte_sel};
            LD_H:    rdata = {{16{half_sel[15]}}, half_sel};
            LD_HU:   rdata = {16'b0, half_sel};
            default: rdata = hit_word;   // LD_W
        endcase
    end

    // a tag may live in one way only
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        req_q.valid |-> $onehot0(hit_vec))
        else $error("multiple ways hit");

endmodule

/* rtl/dcache_pkg.sv */
/*
 * data cache types
 * address fields, CPU and memory port structs, state encodings
 */
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W-1:0]                        tag_t;
    typedef logic [`DC_INDEX_W-1:0]                      index_t;
    typedef logic [`DC_OFFSET_W-1:0]                     offset_t;
    typedef logic [`DC_WAYS-1:0]                         way_vec_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]                 way_id_t;
    typedef logic [`DC_LINE_WORDS-1:0][`DC_DATA_W-1:0]   line_t;

    typedef enum logic [2:0] {LD_B, LD_BU, LD_H, LD_HU, LD_W} load_type_e;
    typedef enum logic {OP_LOAD, OP_STORE} mem_op_e;

    typedef enum logic [2:0] {
        LOOKUP, MISS_DIRTY, WRITEBACK, MISS_CLEAN, REFILL, REFILL_DONE
    } miss_state_e;

    typedef struct packed {
        logic                   valid;
        mem_op_e                op;
        logic [`DC_ADDR_W-1:0]  addr;
        logic [3:0]             wstrb;
        logic [`DC_DATA_W-1:0]  wdata;
        load_type_e             load_type;
    } cpu_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef struct packed {
        logic                   rd_req;
        logic [`DC_ADDR_W-1:0]  rd_addr;
        logic                   wr_req;
        logic [`DC_ADDR_W-1:0]  wr_addr;
        line_t                  wr_line;
    } mem_req_t;

    typedef struct packed {
        logic  rd_rdy;
        logic  wr_rdy;
        logic  ret_valid;
        line_t ret_line;
        logic  wr_done;
    } mem_rsp_t;

    function automatic tag_t addr_tag(input logic [`DC_ADDR_W-1:0] addr);
        return addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    endfunction

    function automatic index_t addr_index(input logic [`DC_ADDR_W-1:0] addr);
        return addr[`DC_OFFSET_W +: `DC_INDEX_W];
    endfunction

    function automatic offset_t addr_offset(input logic [`DC_ADDR_W-1:0] addr);
        return addr[`DC_OFFSET_W-1:0];
    endfunction

endpackage

/* rtl/dcache_top.sv */
/*
 * 4-way write-back data cache
 * CPU load/store port in front, line-wide memory port behind
 */
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dcache_pkg::cpu_req_t   req,
    output logic                   busy,
    output logic [`DC_DATA_W-1:0]  rdata,
    output dcache_pkg::mem_req_t   mem_req,
    input  dcache_pkg::mem_rsp_t   mem_rsp
);
    import dcache_pkg::*;

    index_t                rd_index;
    index_t                wr_index;
    index_t                miss_index;
    index_t                store_index;
    tag_t                  miss_tag;
    tagv_t [`DC_WAYS-1:0]  tagv_rdata;
    way_vec_t              dirty_rdata;
    line_t [`DC_WAYS-1:0]  line_rdata;
    way_id_t               victim;
    way_vec_t              hit_vec;
    logic                  plru_update;
    logic                  miss;
    tagv_t                 victim_tagv;
    logic                  victim_dirty;
    line_t                 victim_line;
    tagv_t                 refill_tagv;
    line_t                 refill_line;
    logic                  refill_done;
    way_vec_t              refill_we;
    way_vec_t              store_we;
    line_t                 store_line;
    way_vec_t              dirty_we;
    way_vec_t              arr_dirty_we;
    way_vec_t              line_we;
    line_t                 line_wdata;
    logic                  refilling;

    // refill and store writes share the array write port
    assign refilling    = |refill_we;
    assign wr_index     = refilling ? miss_index : store_index;
    assign line_we      = store_we | refill_we;
    assign line_wdata   = refilling ? refill_line : store_line;
    assign arr_dirty_we = dirty_we | refill_we;

    dcache_arrays u_arrays (
        .clk, .rst_n, .rd_index, .tagv_rdata, .dirty_rdata, .line_rdata, .wr_index,
        .line_we, .line_wdata,
        .tagv_we     (refill_we),
        .tagv_wdata  (refill_tagv),
        .dirty_we    (arr_dirty_we),
        .dirty_wdata (~refilling)   // refill leaves the line clean
    );

    dcache_lookup u_lookup (
        .clk, .rst_n, .req, .busy, .rdata, .rd_index, .tagv_rdata, .dirty_rdata,
        .line_rdata, .victim, .hit_vec, .plru_update, .miss, .miss_tag, .miss_index,
        .victim_tagv, .victim_dirty, .victim_line, .refill_done, .store_we,
        .store_index, .store_line, .dirty_we
    );

    plru_tree u_plru (
        .clk, .rst_n,
        .index  (miss_index),
        .access (hit_vec),
        .update (plru_update),
        .victim
    );

    miss_ctrl u_miss (
        .clk, .rst_n, .miss, .miss_tag, .miss_index, .victim, .victim_tagv,
        .victim_dirty, .victim_line, .mem_req, .mem_rsp, .refill_we, .refill_tagv,
        .refill_line, .refill_done
    );

endmodule

/* rtl/miss_ctrl.sv */
/*
 * miss controller
 * writes back a dirty victim, then refills the line in one beat
 */
`timescale 1ns/1ps
`include "dcache_config.svh"

module miss_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  miss,
    input  dcache_pkg::tag_t      miss_tag,
    input  dcache_pkg::index_t    miss_index,
    input  dcache_pkg::way_id_t   victim,
    input  dcache_pkg::tagv_t     victim_tagv,
    input  logic                  victim_dirty,
    input  dcache_pkg::line_t     victim_line,
    output dcache_pkg::mem_req_t  mem_req,
    input  dcache_pkg::mem_rsp_t  mem_rsp,
    output dcache_pkg::way_vec_t  refill_we,
    output dcache_pkg::tagv_t     refill_tagv,
    output dcache_pkg::line_t     refill_line,
    output logic                  refill_done
);
    import dcache_pkg::*;

    miss_state_e state;
    miss_state_e state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= LOOKUP;
        else
            state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (miss)
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
            end
            MISS_DIRTY: begin
                if (mem_rsp.wr_rdy)
                    state_next = WRITEBACK;
            end
            WRITEBACK: begin
                if (mem_rsp.wr_done)
                    state_next = MISS_CLEAN;
            end
            MISS_CLEAN: begin
                if (mem_rsp.rd_rdy)
                    state_next = REFILL;
            end
            REFILL: begin
                if (mem_rsp.ret_valid)
                    state_next = REFILL_DONE;
            end
            default: state_next = LOOKUP;   // REFILL_DONE
        endcase
    end

    always_comb begin
        mem_req.rd_req  = (state == MISS_CLEAN);
        mem_req.rd_addr = {miss_tag, miss_index, {`DC_OFFSET_W{1'b0}}};
        mem_req.wr_req  = (state == MISS_DIRTY);
        mem_req.wr_addr = {victim_tagv.tag, miss_index, {`DC_OFFSET_W{1'b0}}};
        mem_req.wr_line = victim_line;
    end

    // returned line goes straight into the victim way
    assign refill_we   = (state == REFILL && mem_rsp.ret_valid) ? way_vec_t'(1) << victim : '0;
    assign refill_tagv = '{valid: 1'b1, tag: miss_tag};
    assign refill_line = mem_rsp.ret_line;
    assign refill_done = (state == REFILL_DONE);

    a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req.rd_req && mem_req.wr_req))
        else $error("read and write request together");

    // dirty bit on an invalid line would write back garbage
    a_dirty_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (state == LOOKUP && miss && victim_dirty) |-> victim_tagv.valid)
        else $error("dirty victim is not valid");

endmodule

/* rtl/plru_tree.sv */
/*
 * tree pseudo-LRU, three bits per set
 * root picks the pair, the leaf bit picks the way within it
 */
`timescale 1ns/1ps
`include "dcache_config.svh"

module plru_tree (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::index_t   index,
    input  dcache_pkg::way_vec_t access,
    input  logic                 update,
    output dcache_pkg::way_id_t  victim
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0][2:0] tree;
    logic [2:0]               cur;
    logic                     acc_hi;   // accessed way is 2 or 3
    logic                     acc_lo;   // accessed way is odd

    assign cur    = tree[index];
    assign acc_hi = access[2] | access[3];
    assign acc_lo = access[1] | access[3];

    // bit 0 set means the victim sits in the upper pair
    assign victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree <= '0;
        end else if (update) begin
            tree[index][0] <= ~acc_hi;   // point away from the accessed pair
            if (acc_hi)
                tree[index][2] <= ~acc_lo;
            else
                tree[index][1] <= ~acc_lo;
        end
    end

endmodule

/* verification/mem_model.sv */
/*
 * line-wide memory behind the data cache
 * random ready and return delays, contents kept per line, write log
 */
`timescale 1ns/1ps

module mem_model (
    input  logic                 clk,
    input  dcache_pkg::mem_req_t mem_req,
    output dcache_pkg::mem_rsp_t mem_rsp,
    output int                   wr_count
);
    import dcache_pkg::*;

    line_t       mem [logic [31:0]];   // keyed by line address
    logic [31:0] wr_log [$];
    integer      seed;

    // untouched lines hold their word address xor the fill constant
    function automatic line_t read_line(input logic [31:0] addr);
        line_t       l;
        logic [31:0] base;
        base = {addr[31:4], 4'h0};
        if (mem.exists(base))
            return mem[base];
        for (int i = 0; i < 4; i++)
            l[i] = (base + 4 * i) ^ 32'h5a5a_0000;
        return l;
    endfunction

    function automatic int pick_delay();
        return $unsigned($random(seed)) % 4;   // 0 to 3 cycles
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic serve_read();
        logic [31:0] addr;
        addr = mem_req.rd_addr;
        wait_cycles(pick_delay());
        mem_rsp.rd_rdy = 1'b1;
        @(negedge clk);
        mem_rsp.rd_rdy = 1'b0;
        wait_cycles(pick_delay());
        mem_rsp.ret_line  = read_line(addr);
        mem_rsp.ret_valid = 1'b1;
        @(negedge clk);
        mem_rsp.ret_valid = 1'b0;
    endtask

    task automatic serve_write();
        wait_cycles(pick_delay());
        mem[{mem_req.wr_addr[31:4], 4'h0}] = mem_req.wr_line;
        wr_log.push_back(mem_req.wr_addr);
        wr_count       = wr_log.size();
        mem_rsp.wr_rdy = 1'b1;
        @(negedge clk);
        mem_rsp.wr_rdy = 1'b0;
        wait_cycles(pick_delay());
        mem_rsp.wr_done = 1'b1;
        @(negedge clk);
        mem_rsp.wr_done = 1'b0;
    endtask

    initial begin
        seed     = 12101;
        mem_rsp  = '0;
        wr_count = 0;
        @(negedge clk);
        forever begin
            if (mem_req.rd_req)
                serve_read();
            else if (mem_req.wr_req)
                serve_write();
            else
                @(negedge clk);
        end
    end

endmodule

/* verification/tb_dcache.sv */
/*
 * testbench for the 4-way data cache
 * directed and random CPU traffic against a word-level reference model,
 * responses checked by concurrent assertions
 */
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int N_RANDOM        = 400;
    localparam int N_DIRECTED      = 64;
    localparam int WATCHDOG_CYCLES = (N_RANDOM + N_DIRECTED) * 60;

    logic        clk;
    logic        rst_n;
    cpu_req_t    req;
    logic        busy;
    logic [31:0] rdata;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    int          wr_count;
    int          wr_before;

    integer      seed;
    string       test_name;
    logic [31:0] ref_mem [logic [31:0]];   // expected word per touched address

    // request currently in the lookup stage
    logic        started;
    logic        pend_valid;
    logic        pend_load;
    logic        pend_first;
    logic        pend_same_line;
    logic [31:0] pend_addr;
    logic [31:0] pend_data;
    line_t       wb_exp;

    dcache_top u_dut (.clk, .rst_n, .req, .busy, .rdata, .mem_req, .mem_rsp);

    mem_model u_mem (.clk, .mem_req, .mem_rsp, .wr_count);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input logic [127:0] expected, input logic [127:0] actual);
        abort_run($sformatf("Error %s: expected %0h, actual %0h", test_name, expected, actual));
    endtask

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        if (ref_mem.exists(base))
            return ref_mem[base];
        return base ^ 32'h5a5a_0000;
    endfunction

    function automatic line_t ref_line(input logic [31:0] addr);
        line_t l;
        for (int i = 0; i < 4; i++)
            l[i] = ref_word({addr[31:4], 4'h0} + 4 * i);
        return l;
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  wstrb);
        logic [31:0] mask;
        mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
        return (old & ~mask) | (wdata & mask);
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] word,
                                                input logic [1:0]  off,
                                                input load_type_e  lt);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8 * off +: 8];
        h = word[16 * off[1] +: 16];
        case (lt)
            LD_B:    return 32'($signed(b));
            LD_BU:   return 32'(b);
            LD_H:    return 32'($signed(h));
            LD_HU:   return 32'(h);
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] make_addr(input tag_t tag, input index_t idx,
                                              input offset_t off);
        return {tag, idx, off};
    endfunction

    // follows acceptance the way the CPU port defines it
    always @(posedge clk or negedge rst_n) begin
        logic [31:0] word;
        if (!rst_n) begin
            started        <= 1'b0;
            pend_valid     <= 1'b0;
            pend_load      <= 1'b0;
            pend_first     <= 1'b0;
            pend_same_line <= 1'b0;
            pend_addr      <= '0;
            pend_data      <= '0;
        end else begin
            pend_first <= 1'b0;
            if (req.valid)
                started <= 1'b1;
            if (!busy) begin
                pend_valid     <= req.valid;
                pend_first     <= req.valid;
                pend_same_line <= pend_valid && (req.addr[31:4] == pend_addr[31:4]);
                pend_addr      <= req.addr;
                pend_load      <= req.valid && (req.op == OP_LOAD);
                if (req.valid) begin
                    word = ref_word(req.addr);
                    if (req.op == OP_STORE)
                        ref_mem[{req.addr[31:2], 2'b00}] = merge_store(word, req.wdata, req.wstrb);
                    pend_data <= extend_load(word, req.addr[1:0], req.load_type);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (mem_req.wr_req)
            wb_exp = ref_line(mem_req.wr_addr);
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!busy && !mem_req.rd_req && !mem_req.wr_req))
        else abort_run("busy or a memory request went high before the first CPU request");

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        (pend_valid && pend_load && !busy) |-> (rdata == pend_data))
        else report_mismatch($sampled(pend_data), $sampled(rdata));

    a_writeback_line: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req.wr_req && mem_rsp.wr_rdy) |-> (mem_req.wr_line == wb_exp))
        else report_mismatch($sampled(wb_exp), $sampled(mem_req.wr_line));

    // refill fetches the line of the missed request
    a_refill_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.rd_req |-> (mem_req.rd_addr == {pend_addr[31:4], 4'h0}))
        else report_mismatch($sampled({pend_addr[31:4], 4'h0}), $sampled(mem_req.rd_addr));

    // evicted line sits in the same set under another tag
    a_victim_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.wr_req |-> (mem_req.wr_addr[7:0] == {pend_addr[7:4], 4'h0} &&
                            mem_req.wr_addr[31:8] != pend_addr[31:8]))
        else abort_run($sformatf("%s: write-back address %0h is not another line of set %0h",
                                 test_name, $sampled(mem_req.wr_addr),
                                 $sampled(pend_addr[7:4])));

    a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
        (pend_valid && pend_load && pend_first && pend_same_line) |-> !busy)
        else abort_run($sformatf("%s: load to a resident line did not hit", test_name));

    // held until the cache takes it
    task automatic issue(input cpu_req_t r);
        @(negedge clk);
        req = r;
        while (busy)
            @(negedge clk);
    endtask

    task automatic load_from(input logic [31:0] addr, input load_type_e lt);
        cpu_req_t r;
        r           = '0;
        r.valid     = 1'b1;
        r.op        = OP_LOAD;
        r.addr      = addr;
        r.load_type = lt;
        issue(r);
    endtask

    task automatic store_to(input logic [31:0] addr, input logic [3:0] wstrb,
                            input logic [31:0] wdata);
        cpu_req_t r;
        r           = '0;
        r.valid     = 1'b1;
        r.op        = OP_STORE;
        r.addr      = addr;
        r.wstrb     = wstrb;
        r.wdata     = wdata;
        r.load_type = LD_W;
        issue(r);
    endtask

    task automatic drain();
        @(negedge clk);
        req.valid = 1'b0;
        while (busy)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic random_request();
        logic [31:0] addr;
        load_type_e  lt;
        logic [3:0]  strb;
        addr = make_addr({22'h0000f0, 2'($random(seed))}, index_t'($random(seed)),
                         offset_t'($random(seed)));
        if ($random(seed) & 1) begin
            strb = 4'($random(seed));
            store_to({addr[31:2], 2'b00}, (strb == 4'h0) ? 4'hf : strb, $random(seed));
        end else begin
            lt = load_type_e'(3'($unsigned($random(seed)) % 5));
            if (lt == LD_W)
                addr[1:0] = 2'b00;
            else if (lt == LD_H || lt == LD_HU)
                addr[0] = 1'b0;
            load_from(addr, lt);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("timeout, the cache did not finish the request sequence");
    end

    initial begin
        seed      = 12101;
        rst_n     = 1'b0;
        req       = '0;
        wr_before = 0;
        test_name = "reset_idle";
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (8) @(negedge clk);

        test_name = "initial_load";   // fresh lines with every load type
        load_from(make_addr(24'h0081a0, 4'h9, 4'h0), LD_B);
        load_from(make_addr(24'h0081a0, 4'h9, 4'h1), LD_BU);
        load_from(make_addr(24'h0081a0, 4'h9, 4'h6), LD_H);
        load_from(make_addr(24'h0081a0, 4'h9, 4'h8), LD_HU);
        load_from(make_addr(24'h0081a0, 4'h9, 4'hc), LD_W);
        load_from(make_addr(24'h0081a0, 4'h9, 4'h3), LD_B);
        load_from(make_addr(24'h004400, 4'h3, 4'ha), LD_HU);
        drain();

        test_name = "store_forward";
        store_to(make_addr(24'h00c3e0, 4'h2, 4'h0), 4'hf, 32'hdead_beef);
        load_from(make_addr(24'h00c3e0, 4'h2, 4'h0), LD_W);
        store_to(make_addr(24'h00c3e0, 4'h2, 4'h4), 4'b0101, 32'h1122_3344);
        load_from(make_addr(24'h00c3e0, 4'h2, 4'h4), LD_W);
        load_from(make_addr(24'h00c3e0, 4'h2, 4'h6), LD_B);
        load_from(make_addr(24'h00c3e0, 4'h2, 4'h4), LD_HU);
        store_to(make_addr(24'h00c3e0, 4'h2, 4'h8), 4'b1000, 32'h8000_0000);
        load_from(make_addr(24'h00c3e0, 4'h2, 4'hb), LD_B);
        load_from(make_addr(24'h00c3e0, 4'h2, 4'ha), LD_H);
        load_from(make_addr(24'h00c3e0, 4'h2, 4'h0), LD_W);
        drain();

        test_name = "write_back";   // five dirty lines on one index
        wr_before = wr_count;
        for (int k = 0; k < 5; k++)
            store_to(make_addr(tag_t'(24'h00b000 + k), 4'h5, offset_t'(4 * (k % 4))),
                     4'hf, 32'hc0de_0000 | k);
        for (int k = 0; k < 5; k++)
            load_from(make_addr(tag_t'(24'h00b000 + k), 4'h5, offset_t'(4 * (k % 4))), LD_W);
        drain();
        assert (wr_count > wr_before)
            else abort_run("write_back: no dirty line was written back to memory");

        test_name = "hit_timing";
        load_from(make_addr(24'h00d000, 4'h7, 4'h0), LD_W);
        load_from(make_addr(24'h00d000, 4'h7, 4'h4), LD_W);
        load_from(make_addr(24'h00d000, 4'h7, 4'h8), LD_HU);
        load_from(make_addr(24'h00d000, 4'h7, 4'hd), LD_BU);
        store_to(make_addr(24'h00d000, 4'h7, 4'h4), 4'b0011, 32'h0000_f00d);
        load_from(make_addr(24'h00d000, 4'h7, 4'h4), LD_H);
        drain();

        test_name = "random_mix";
        for (int i = 0; i < N_RANDOM; i++)
            random_request();
        drain();

        $display("No errors");
        $finish;
    end

endmodule
